// ==== Bender.yml ====
package:
  name: timer_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/timerPkg.sv
      - rtl/timerCfgIf.sv
      - rtl/timerRegs.sv
      - rtl/timerCore.sv
      - rtl/timerSubsystem.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/timerTb.sv

// ==== files.f ====
+incdir+include
rtl/timerPkg.sv
rtl/timerCfgIf.sv
rtl/timerRegs.sv
rtl/timerCore.sv
rtl/timerSubsystem.sv
verification/timerTb.sv

// ==== include/timer_defs.svh ====
`ifndef TIMER_DEFS_SVH
`define TIMER_DEFS_SVH

// ####################
// channel and datapath sizes
// ####################

`define TIMER_NUM_CH 2
`define TIMER_WIDTH 32
`define TIMER_ADDR_W 8

// ####################
// address map fields
// ####################

`define TIMER_REG_LSB 2
`define TIMER_REG_MSB 4
`define TIMER_CH_BIT 5

`endif

// ==== rtl/timerCfgIf.sv ====
`timescale 1ns/1ps
`include "timer_defs.svh"

interface timerCfgIf;
  import timerPkg::*;

  logic [`TIMER_WIDTH-1:0] overflowVal;
  logic [`TIMER_WIDTH-1:0] compareVal;
  timerCtrl_t              ctrl;
  logic                    counterClear;  // one-cycle strobe.
  logic                    statusClear;   // one-cycle strobe.
  logic [`TIMER_WIDTH-1:0] counterVal;
  logic [1:0]              status;        // bit 0 overflow, bit 1 compare.

  modport regs (
    output overflowVal, compareVal, ctrl, counterClear, statusClear,
    input  counterVal, status
  );

  modport core (
    input  overflowVal, compareVal, ctrl, counterClear, statusClear,
    output counterVal, status
  );

endinterface

// ==== rtl/timerCore.sv ====
`timescale 1ns/1ps
`include "timer_defs.svh"

module timerCore (
  input  logic    pclk,
  input  logic    nreset,
  timerCfgIf.core cfg
);

  logic [`TIMER_WIDTH-1:0] count;
  logic [1:0]              status;
  logic                    running;
  logic                    atOverflow;
  logic                    atCompare;
  logic                    ovfEvent;
  logic                    cmpEvent;

  // ####################
  // event detection
  // ####################

  assign running    = cfg.ctrl.timerEn && !cfg.counterClear;
  assign atOverflow = running && (count == cfg.overflowVal);
  assign atCompare  = running && (count == cfg.compareVal);

  // overflow has priority over compare.
  assign ovfEvent = atOverflow && cfg.ctrl.interruptEn && cfg.ctrl.overflowEn;
  assign cmpEvent = atCompare && !atOverflow && cfg.ctrl.interruptEn && cfg.ctrl.compareEn;

  // ####################
  // counter
  // ####################

  always_ff @(posedge pclk) begin
    if (!nreset) begin
      count <= '0;
    end else if (cfg.counterClear) begin
      count <= '0;
    end else if (cfg.ctrl.timerEn) begin
      if (count == cfg.overflowVal) begin
        count <= '0;  // wrap.
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // ####################
  // sticky status
  // ####################

  always_ff @(posedge pclk) begin
    if (!nreset) begin
      status <= 2'b00;
    end else if (cfg.statusClear) begin
      status <= 2'b00;  // clear beats a new event.
    end else begin
      status <= status | {cmpEvent, ovfEvent};
    end
  end

  assign cfg.counterVal = count;
  assign cfg.status     = status;

endmodule

// ==== rtl/timerPkg.sv ====
package timerPkg;

  // ####################
  // register offsets that act as bus opcodes
  // ####################

  typedef enum logic [2:0] {
    regOverflow = 3'd0,  // write also clears the counter.
    regCounter  = 3'd1,  // read only.
    regControl  = 3'd2,
    regCompare  = 3'd3,
    regStatus   = 3'd4   // clear on read.
  } timerReg_e;

  // ####################
  // control register bits
  // ####################

  typedef struct packed {
    logic overflowEn;
    logic compareEn;
    logic interruptEn;
    logic timerEn;
  } timerCtrl_t;

endpackage

// ==== rtl/timerRegs.sv ====
`timescale 1ns/1ps
`include "timer_defs.svh"

module timerRegs (
  input  logic                     pclk,
  input  logic                     nreset,
  input  logic                     busWriteEn,
  input  logic                     busReadEn,
  input  logic [`TIMER_ADDR_W-1:0] busAddr,
  input  logic [`TIMER_WIDTH-1:0]  busWriteData,
  output logic [`TIMER_WIDTH-1:0]  busReadData,
  output logic                     fabint,
  timerCfgIf.regs                  cfg [`TIMER_NUM_CH]
);
  import timerPkg::*;

  timerReg_e               regSel;
  logic                    chSel;
  logic                    readAcc;
  logic [`TIMER_WIDTH-1:0] readMux;

  logic [`TIMER_WIDTH-1:0] overflowReg [`TIMER_NUM_CH];
  logic [`TIMER_WIDTH-1:0] compareReg [`TIMER_NUM_CH];
  timerCtrl_t              ctrlReg [`TIMER_NUM_CH];
  logic [`TIMER_NUM_CH-1:0] counterClearReg;
  logic [`TIMER_NUM_CH-1:0] statusClearReg;

  logic [`TIMER_WIDTH-1:0] counterArr [`TIMER_NUM_CH];
  logic [1:0]              statusArr [`TIMER_NUM_CH];
  logic [`TIMER_NUM_CH-1:0] statusAny;

  // ####################
  // address decode
  // ####################

  assign regSel  = timerReg_e'(busAddr[`TIMER_REG_MSB:`TIMER_REG_LSB]);
  assign chSel   = busAddr[`TIMER_CH_BIT];
  assign readAcc = busReadEn && !busWriteEn;  // write wins.

  // ####################
  // per-channel registers
  // ####################

  for (genvar g = 0; g < `TIMER_NUM_CH; g++) begin : genCh
    logic chHit;

    assign chHit = (int'(chSel) == g);

    always_ff @(posedge pclk) begin
      if (!nreset) begin
        overflowReg[g]     <= '0;
        compareReg[g]      <= '0;
        ctrlReg[g]         <= '0;
        counterClearReg[g] <= 1'b0;
        statusClearReg[g]  <= 1'b0;
      end else begin
        counterClearReg[g] <= busWriteEn && chHit && (regSel == regOverflow);
        statusClearReg[g]  <= readAcc && chHit && (regSel == regStatus);
        if (busWriteEn && chHit) begin
          case (regSel)
            regOverflow: overflowReg[g] <= busWriteData;
            regControl:  ctrlReg[g] <= timerCtrl_t'(busWriteData[$bits(timerCtrl_t)-1:0]);
            regCompare:  compareReg[g] <= busWriteData;
            default: ;  // counter and status ignore writes.
          endcase
        end
      end
    end

    assign cfg[g].overflowVal  = overflowReg[g];
    assign cfg[g].compareVal   = compareReg[g];
    assign cfg[g].ctrl         = ctrlReg[g];
    assign cfg[g].counterClear = counterClearReg[g];
    assign cfg[g].statusClear  = statusClearReg[g];

    assign counterArr[g] = cfg[g].counterVal;
    assign statusArr[g]  = cfg[g].status;
    assign statusAny[g]  = |cfg[g].status;
  end

  // ####################
  // read path and interrupt
  // ####################

  always_comb begin
    readMux = '0;
    case (regSel)
      regOverflow: readMux = overflowReg[chSel];
      regCounter:  readMux = counterArr[chSel];
      regControl:  readMux[$bits(timerCtrl_t)-1:0] = ctrlReg[chSel];  // zero-extended.
      regCompare:  readMux = compareReg[chSel];
      regStatus:   readMux[1:0] = statusArr[chSel];
      default:     readMux = '0;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (!nreset) begin
      busReadData <= '0;
      fabint      <= 1'b0;
    end else begin
      if (readAcc) begin
        busReadData <= readMux;  // holds until the next read.
      end
      fabint <= |statusAny;
    end
  end

endmodule

// ==== rtl/timerSubsystem.sv ====
`timescale 1ns/1ps
`include "timer_defs.svh"

module timerSubsystem (
  input  logic                     pclk,
  input  logic                     nreset,
  input  logic                     busWriteEn,
  input  logic                     busReadEn,
  input  logic [`TIMER_ADDR_W-1:0] busAddr,
  input  logic [`TIMER_WIDTH-1:0]  busWriteData,
  output logic [`TIMER_WIDTH-1:0]  busReadData,
  output logic                     fabint
);

  // ####################
  // channel links
  // ####################

  timerCfgIf cfgIf [`TIMER_NUM_CH] ();

  // ####################
  // register block
  // ####################

  timerRegs regs0 (
    .pclk         (pclk),
    .nreset       (nreset),
    .busWriteEn   (busWriteEn),
    .busReadEn    (busReadEn),
    .busAddr      (busAddr),
    .busWriteData (busWriteData),
    .busReadData  (busReadData),
    .fabint       (fabint),
    .cfg          (cfgIf)
  );

  // ####################
  // timer channels
  // ####################

  for (genvar g = 0; g < `TIMER_NUM_CH; g++) begin : genCore
    timerCore core0 (
      .pclk   (pclk),
      .nreset (nreset),
      .cfg    (cfgIf[g])
    );
  end

endmodule

// ==== verification/timerTb.sv ====
`timescale 1ns/1ps
`include "timer_defs.svh"

module timerTb;
  import timerPkg::*;

  typedef enum logic [1:0] {opWrite, opRead, opIdle} tbOp_e;

  localparam int maxEntries = 64;

  logic                     pclk;
  logic                     nreset;
  logic                     busWriteEn;
  logic                     busReadEn;
  logic [`TIMER_ADDR_W-1:0] busAddr;
  logic [`TIMER_WIDTH-1:0]  busWriteData;
  logic [`TIMER_WIDTH-1:0]  busReadData;
  logic                     fabint;

  // ####################
  // stimulus and expected-value table
  // ####################

  tbOp_e                    opTab [maxEntries];
  logic [`TIMER_ADDR_W-1:0] addrTab [maxEntries];
  logic [`TIMER_WIDTH-1:0]  dataTab [maxEntries];  // idle entries keep the cycle count here.
  logic [`TIMER_WIDTH-1:0]  expTab [maxEntries];
  bit                       intChkTab [maxEntries];
  bit                       expIntTab [maxEntries];
  string                    nameTab [maxEntries];

  int     nEntries = 0;
  int     idleSum = 0;
  int     errCount = 0;
  int     cycleCount = 0;
  int     cycleLimit = 0;
  integer seed = 32'h2d396c56;

  timerSubsystem dut0 (
    .pclk         (pclk),
    .nreset       (nreset),
    .busWriteEn   (busWriteEn),
    .busReadEn    (busReadEn),
    .busAddr      (busAddr),
    .busWriteData (busWriteData),
    .busReadData  (busReadData),
    .fabint       (fabint)
  );

  initial begin
    pclk = 1'b0;
    forever #20 pclk = ~pclk;
  end

  always @(posedge pclk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("timeout: the table did not finish within %0d cycles", cycleLimit);
      $display("Errors found");
      $finish;
    end
  end

  // builds a bus address from the channel and the register offset.
  function automatic logic [`TIMER_ADDR_W-1:0] regAddr(input int ch, input timerReg_e r);
    regAddr = '0;
    regAddr[`TIMER_CH_BIT] = ch[0];
    regAddr[`TIMER_REG_MSB:`TIMER_REG_LSB] = r;
  endfunction

  task automatic addEntry(input tbOp_e op, input logic [`TIMER_ADDR_W-1:0] addr,
                          input logic [`TIMER_WIDTH-1:0] data,
                          input logic [`TIMER_WIDTH-1:0] expected, input string name);
    opTab[nEntries]     = op;
    addrTab[nEntries]   = addr;
    dataTab[nEntries]   = data;
    expTab[nEntries]    = expected;
    intChkTab[nEntries] = 1'b0;
    expIntTab[nEntries] = 1'b0;
    nameTab[nEntries]   = name;
    nEntries++;
  endtask

  task automatic addWrite(input int ch, input timerReg_e r,
                          input logic [`TIMER_WIDTH-1:0] data, input string name);
    addEntry(opWrite, regAddr(ch, r), data, '0, name);
  endtask

  task automatic addRead(input int ch, input timerReg_e r,
                         input logic [`TIMER_WIDTH-1:0] expected, input string name);
    addEntry(opRead, regAddr(ch, r), '0, expected, name);
  endtask

  task automatic addIdle(input int cycles, input string name);
    addEntry(opIdle, '0, cycles, '0, name);
    idleSum += cycles;
  endtask

  // adds a fabint check to the last entry.
  task automatic markInt(input bit expected);
    intChkTab[nEntries-1] = 1'b1;
    expIntTab[nEntries-1] = expected;
  endtask

  task automatic buildTable();
    logic [`TIMER_WIDTH-1:0] rndOvf [2];
    logic [`TIMER_WIDTH-1:0] rndCmp [2];
    logic [`TIMER_WIDTH-1:0] rndCtl [2];
    for (int ch = 0; ch < 2; ch++) begin
      addRead(ch, regOverflow, 0, "reset overflow");
      addRead(ch, regCounter, 0, "reset counter");
      addRead(ch, regControl, 0, "reset control");
      addRead(ch, regCompare, 0, "reset compare");
      addRead(ch, regStatus, 0, "reset status");
    end
    markInt(1'b0);
    for (int ch = 0; ch < 2; ch++) begin
      rndOvf[ch] = $random(seed);
      rndCmp[ch] = $random(seed);
      rndCtl[ch] = $random(seed);
      addWrite(ch, regOverflow, rndOvf[ch], "rw overflow");
      addWrite(ch, regCompare, rndCmp[ch], "rw compare");
      addWrite(ch, regControl, rndCtl[ch], "rw control");
    end
    for (int ch = 0; ch < 2; ch++) begin
      addRead(ch, regOverflow, rndOvf[ch], "rw overflow");
      addRead(ch, regCompare, rndCmp[ch], "rw compare");
      addRead(ch, regControl, rndCtl[ch] & 32'hf, "rw control");  // low four bits only.
      addWrite(ch, regControl, 0, "rw stop");
    end
    // ####################
    // counter clear while disabled
    // ####################
    addWrite(0, regOverflow, 1000, "clear setup");
    addWrite(0, regControl, 32'h1, "clear run");
    addIdle(5, "clear run");
    addWrite(0, regControl, 0, "clear stop");
    addWrite(0, regOverflow, 1000, "clear write");
    addIdle(1, "clear wait");
    addRead(0, regCounter, 0, "clear counter first");
    addIdle(3, "clear gap");
    addRead(0, regCounter, 0, "clear counter second");
    // ####################
    // overflow and compare status
    // ####################
    addWrite(0, regOverflow, 5, "ovf setup");
    addWrite(0, regControl, 32'hb, "ovf enable");
    addIdle(12, "ovf fabint");
    markInt(1'b1);
    addWrite(0, regControl, 0, "ovf stop");
    addRead(0, regStatus, 1, "ovf status first");
    addIdle(2, "ovf clear wait");
    addRead(0, regStatus, 0, "ovf status second");
    markInt(1'b0);
    addWrite(0, regCompare, 3, "cmp setup");
    addWrite(0, regOverflow, 1000, "cmp setup");
    addWrite(0, regControl, 32'h7, "cmp enable");
    addIdle(10, "cmp run");
    addRead(0, regStatus, 2, "cmp status");
    markInt(1'b1);
    addWrite(0, regControl, 32'h3, "cmp masked");
    addWrite(0, regOverflow, 1000, "cmp rerun");
    addIdle(10, "cmp masked fabint");
    markInt(1'b0);
    addRead(0, regStatus, 0, "cmp masked status");
    markInt(1'b0);
    addWrite(0, regControl, 0, "cmp stop");
    // ####################
    // channel independence
    // ####################
    addWrite(1, regOverflow, 4, "ch1 setup");
    addWrite(1, regControl, 32'hb, "ch1 enable");
    addIdle(10, "ch1 fabint");
    markInt(1'b1);
    addRead(0, regStatus, 0, "ch0 status");
    markInt(1'b1);
    addWrite(1, regControl, 0, "ch1 stop");
    addRead(1, regStatus, 1, "ch1 status");
    addIdle(2, "ch1 clear wait");
    markInt(1'b0);
  endtask

  task automatic checkValue(input string name, input logic [`TIMER_WIDTH-1:0] expected,
                            input logic [`TIMER_WIDTH-1:0] actual);
    if (actual !== expected) begin
      errCount++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // each entry starts and ends 2 ns after a rising edge.
  task automatic applyEntry(input int i);
    case (opTab[i])
      opWrite: begin
        busAddr      = addrTab[i];
        busWriteData = dataTab[i];
        busWriteEn   = 1'b1;
        @(posedge pclk);
        #2;
        busWriteEn   = 1'b0;
      end
      opRead: begin
        busAddr   = addrTab[i];
        busReadEn = 1'b1;
        @(posedge pclk);
        #2;
        busReadEn = 1'b0;
        checkValue(nameTab[i], expTab[i], busReadData);  // loaded on the strobe edge.
      end
      default: begin
        repeat (dataTab[i]) begin
          @(posedge pclk);
          #2;
        end
      end
    endcase
    if (intChkTab[i]) begin
      checkValue({nameTab[i], " fabint"}, {31'b0, expIntTab[i]}, {31'b0, fabint});
    end
  endtask

  // ####################
  // main sequence
  // ####################

  initial begin
    nreset       = 1'b0;
    busWriteEn   = 1'b0;
    busReadEn    = 1'b0;
    busAddr      = '0;
    busWriteData = '0;
    buildTable();
    cycleLimit = nEntries + idleSum + 100;
    repeat (16) @(posedge pclk);
    #2;
    nreset = 1'b1;
    for (int i = 0; i < nEntries; i++) begin
      applyEntry(i);
    end
    $display("%0d errors in %0d table entries", errCount, nEntries);
    if (errCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
